//--- src/csd_types_pkg.sv
`default_nettype none

package csd_types_pkg;

    // Input sample width.
    localparam int SAMPLE_W = 16;

    // Carry-save and product width, holds every product exactly.
    localparam int TERM_W = 32;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Sign-extended samples, partial terms, sums and carries.
    typedef logic [TERM_W-1:0] term_t;

    // Finished product at the output.
    typedef logic [TERM_W-1:0] product_t;

endpackage

`default_nettype wire

//--- src/csd_coef_pkg.sv
`default_nettype none

package csd_coef_pkg;

    localparam int NUM_TAPS   = 4;
    localparam int MAX_DIGITS = 5; // Most nonzero CSD digits in any tap.

    typedef logic [4:0] shift_t;

    // Power of two of each digit, digit 0 first.
    // Tap 0: -2^10 +2^8 -2^6 -2^2 +1.
    // Tap 1: -2^7 -2^4 -2^1.
    // Tap 2: +2^10 +2^8 -2^6 +2^2 +1.
    // Tap 3: +2^9 -2^7 -2^4 -1.
    localparam shift_t csd_shift [NUM_TAPS][MAX_DIGITS] = '{
        '{5'd10, 5'd8, 5'd6, 5'd2, 5'd0},
        '{5'd7,  5'd4, 5'd1, 5'd0, 5'd0},
        '{5'd10, 5'd8, 5'd6, 5'd2, 5'd0},
        '{5'd9,  5'd7, 5'd4, 5'd0, 5'd0}
    };

    // Bit i set means digit i is minus one.
    localparam logic [MAX_DIGITS-1:0] csd_neg [NUM_TAPS] = '{
        5'b01101,
        5'b00111,
        5'b00100,
        5'b01110
    };

    // Bit i set means digit i is present.
    localparam logic [MAX_DIGITS-1:0] csd_used [NUM_TAPS] = '{
        5'b11111,
        5'b00111,
        5'b11111,
        5'b01111
    };

    localparam int coef_value [NUM_TAPS] = '{-835, -146, 1221, 367};

endpackage

`default_nettype wire

//--- src/csd_input_stage.sv
`timescale 1ns/1ps
`default_nettype none

module csd_input_stage (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire csd_types_pkg::sample_t x,
    input  wire logic                 x_valid,
    output csd_types_pkg::term_t      x_ext,
    output logic                      x_ext_valid
);

    import csd_types_pkg::*;

    term_t x_sext;

    // Replicate the sign bit up to term width.
    assign x_sext = {{(TERM_W-SAMPLE_W){x[SAMPLE_W-1]}}, x};

    always_ff @(posedge clk) begin
        if (x_valid) begin
            x_ext <= x_sext; // Holds its value between strobes.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x_ext_valid <= 1'b0;
        end else begin
            x_ext_valid <= x_valid;
        end
    end

endmodule

`default_nettype wire

//--- src/csd_tap.sv
`timescale 1ns/1ps
`default_nettype none

module csd_tap #(
    parameter int TAP = 0
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire csd_types_pkg::term_t x_ext,
    input  wire logic                 x_ext_valid,
    output csd_types_pkg::term_t      cs_sum,
    output csd_types_pkg::term_t      cs_carry,
    output logic                      tree_valid
);

    import csd_types_pkg::*;
    import csd_coef_pkg::*;

    // 3:2 compressor, sum half.
    function automatic term_t csa_sum(term_t a, term_t b, term_t c);
        return a ^ b ^ c;
    endfunction

    // 3:2 compressor, carry half (not yet shifted).
    function automatic term_t csa_carry(term_t a, term_t b, term_t c);
        return (a & b) | (b & c) | (a & c);
    endfunction

    term_t term [MAX_DIGITS];

    // One signed partial term per CSD digit.
    for (genvar i = 0; i < MAX_DIGITS; i++) begin : g_term
        term_t shifted;

        assign shifted = x_ext << csd_shift[TAP][i];

        assign term[i] = !csd_used[TAP][i] ? '0 :
                         csd_neg[TAP][i]   ? -shifted : shifted;
    end

    term_t s1;
    term_t c1;
    term_t s2;
    term_t c2;
    term_t s3;
    term_t c3;
    term_t s4;
    term_t c4;

    // Level 1: two compressors side by side.
    assign s1 = csa_sum(term[0], term[1], term[2]);
    assign c1 = csa_carry(term[0], term[1], term[2]);
    assign s2 = csa_sum(term[3], term[4], '0);
    assign c2 = csa_carry(term[3], term[4], '0);

    // Level 2.
    assign s3 = csa_sum(s1, s2, c1 << 1);
    assign c3 = csa_carry(s1, s2, c1 << 1);

    // Level 3 folds in the level 1 carry left over.
    assign s4 = csa_sum(s3, c2 << 1, c3 << 1);
    assign c4 = csa_carry(s3, c2 << 1, c3 << 1);

    always_ff @(posedge clk) begin
        if (x_ext_valid) begin
            cs_sum   <= s4;
            cs_carry <= c4; // Shifted in the output stage.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tree_valid <= 1'b0;
        end else begin
            tree_valid <= x_ext_valid;
        end
    end

endmodule

`default_nettype wire

//--- src/csd_output_stage.sv
`timescale 1ns/1ps
`default_nettype none

module csd_output_stage (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire csd_types_pkg::term_t cs_sum   [csd_coef_pkg::NUM_TAPS],
    input  wire csd_types_pkg::term_t cs_carry [csd_coef_pkg::NUM_TAPS],
    input  wire logic                 tree_valid,
    output csd_types_pkg::product_t   y        [csd_coef_pkg::NUM_TAPS],
    output logic                      y_valid
);

    import csd_types_pkg::*;
    import csd_coef_pkg::*;

    product_t product [NUM_TAPS];

    // One carry-propagate add per tap.
    always_comb begin
        for (int t = 0; t < NUM_TAPS; t++) begin
            product[t] = cs_sum[t] + (cs_carry[t] << 1);
        end
    end

    // Products are zero until the first result arrives.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int t = 0; t < NUM_TAPS; t++) begin
                y[t] <= '0;
            end
        end else if (tree_valid) begin
            for (int t = 0; t < NUM_TAPS; t++) begin
                y[t] <= product[t];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            y_valid <= 1'b0;
        end else begin
            y_valid <= tree_valid;
        end
    end

endmodule

`default_nettype wire

//--- src/csd_mult_bank.sv
`timescale 1ns/1ps
`default_nettype none

module csd_mult_bank (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire csd_types_pkg::sample_t x,
    input  wire logic                   x_valid,
    output csd_types_pkg::product_t     y [csd_coef_pkg::NUM_TAPS],
    output logic                        y_valid
);

    import csd_types_pkg::*;
    import csd_coef_pkg::*;

    term_t x_ext;
    logic  x_ext_valid;

    term_t cs_sum   [NUM_TAPS];
    term_t cs_carry [NUM_TAPS];
    logic  tap_valid [NUM_TAPS]; // Identical in every tap.

    csd_input_stage csd_input_stage_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .x           (x),
        .x_valid     (x_valid),
        .x_ext       (x_ext),
        .x_ext_valid (x_ext_valid)
    );

    for (genvar t = 0; t < NUM_TAPS; t++) begin : g_tap
        csd_tap #(
            .TAP (t)
        ) csd_tap_i (
            .clk         (clk),
            .rst_n       (rst_n),
            .x_ext       (x_ext),
            .x_ext_valid (x_ext_valid),
            .cs_sum      (cs_sum[t]),
            .cs_carry    (cs_carry[t]),
            .tree_valid  (tap_valid[t])
        );
    end

    csd_output_stage csd_output_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cs_sum     (cs_sum),
        .cs_carry   (cs_carry),
        .tree_valid (tap_valid[0]),
        .y          (y),
        .y_valid    (y_valid)
    );

endmodule

`default_nettype wire

//--- test/tb_csd_mult_bank.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csd_mult_bank;

    import csd_types_pkg::*;
    import csd_coef_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 8;
    localparam int LATENCY      = 3; // Rising edges from strobe to y_valid.
    localparam int NUM_CORNER   = 5;
    localparam int NUM_RANDOM   = 200;
    localparam int NUM_GAPPED   = 100;
    localparam int MAX_GAP      = 3;
    localparam int DRAIN_LIMIT  = 20;

    // Worst case cycles over all tests, with room for every drain.
    localparam int RUN_CYCLES = RESET_CYCLES + IDLE_CYCLES + NUM_CORNER + LATENCY + 1
                              + NUM_RANDOM + NUM_GAPPED * (MAX_GAP + 1) + 5 * DRAIN_LIMIT;
    localparam int TIMEOUT_NS = RUN_CYCLES * CLK_PERIOD + 2000;

    logic     clk = 1'b0;
    logic     rst_n;
    sample_t  x;
    logic     x_valid;
    product_t y [NUM_TAPS];
    logic     y_valid;

    integer   seed = 32'h3fe4;
    string    test_name;
    product_t expected_q [$]; // NUM_TAPS entries per sample, tap 0 first.

    logic [LATENCY-1:0] valid_pipe = '0;

    csd_mult_bank csd_mult_bank_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .x       (x),
        .x_valid (x_valid),
        .y       (y),
        .y_valid (y_valid)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Reference model of one product.
    function automatic product_t ref_product(input sample_t s, input int tap);
        longint p;
        p = longint'(s) * longint'(coef_value[tap]);
        return p[TERM_W-1:0];
    endfunction

    task automatic check_product(input product_t expected, input product_t actual, input int tap);
        if (actual !== expected) begin
            $display("ERR %s tap %0d: expected %0d, actual %0d",
                     test_name, tap, $signed(expected), $signed(actual));
            $display("SIMULATION FAILED");
            $fatal(1, "Product mismatch.");
        end
    endtask

    task automatic check_valid(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %s y_valid: expected %b, actual %b", test_name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "Output strobe mismatch.");
        end
    endtask

    task automatic check_quiet();
        check_valid(1'b0, y_valid);
        for (int t = 0; t < NUM_TAPS; t++) begin
            check_product('0, y[t], t);
        end
    endtask

    task automatic drive_sample(input sample_t s);
        @(negedge clk);
        x       = s;
        x_valid = 1'b1;
        for (int t = 0; t < NUM_TAPS; t++) begin
            expected_q.push_back(ref_product(s, t));
        end
    endtask

    // Junk on x while the strobe is low.
    task automatic drive_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            x       = sample_t'($random(seed));
            x_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                $display("Outputs stopped arriving with %0d products still expected.",
                         expected_q.size());
                $display("SIMULATION FAILED");
                $fatal(1, "Drain timeout.");
            end
        end
    endtask

    // Expected strobe is x_valid delayed by the pipeline depth.
    always @(posedge clk) begin
        valid_pipe <= {valid_pipe[LATENCY-2:0], x_valid};
    end

    always @(negedge clk) begin
        check_valid(valid_pipe[LATENCY-1], y_valid);
        if (y_valid) begin
            if (expected_q.size() < NUM_TAPS) begin
                $display("Output strobe seen while no sample was waiting for it.");
                $display("SIMULATION FAILED");
                $fatal(1, "Unexpected output.");
            end
            for (int t = 0; t < NUM_TAPS; t++) begin
                check_product(expected_q.pop_front(), y[t], t);
            end
        end
    end

    task automatic test_reset_quiet();
        test_name = "reset_quiet";
        for (int i = 0; i < RESET_CYCLES; i++) begin
            drive_idle(1);
            check_quiet();
        end
        rst_n = 1'b1; // Released on a falling edge.
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            drive_idle(1);
            check_quiet();
        end
    endtask

    task automatic test_corner_samples();
        sample_t corners [NUM_CORNER];
        test_name = "corner_samples";
        corners = '{16'sh0000, 16'sh0001, 16'shffff, 16'sh7fff, 16'sh8000};
        for (int i = 0; i < NUM_CORNER; i++) begin
            drive_sample(corners[i]);
        end
        drive_idle(1);
        wait_drain();
    endtask

    task automatic test_latency();
        test_name = "latency";
        drive_sample(sample_t'($random(seed)));
        for (int i = 1; i <= LATENCY + 1; i++) begin
            @(negedge clk);
            x_valid = 1'b0;
            check_valid(i == LATENCY, y_valid);
        end
        wait_drain();
    endtask

    task automatic test_back_to_back_random();
        test_name = "back_to_back_random";
        for (int i = 0; i < NUM_RANDOM; i++) begin
            drive_sample(sample_t'($random(seed)));
        end
        drive_idle(1);
        wait_drain();
    endtask

    task automatic test_gapped_stream();
        int gap;
        test_name = "gapped_stream";
        for (int i = 0; i < NUM_GAPPED; i++) begin
            gap = $unsigned($random(seed)) % (MAX_GAP + 1);
            drive_idle(gap);
            drive_sample(sample_t'($random(seed)));
        end
        drive_idle(1);
        wait_drain();
    endtask

    initial begin
        rst_n     = 1'b0;
        x         = '0;
        x_valid   = 1'b0;
        test_name = "startup";
        test_reset_quiet();
        test_corner_samples();
        test_latency();
        test_back_to_back_random();
        test_gapped_stream();
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns before the tests finished.", TIMEOUT_NS);
        $display("SIMULATION FAILED");
        $fatal(1, "Timeout.");
    end

endmodule

`default_nettype wire

//--- csd_mult_bank.f
src/csd_types_pkg.sv
src/csd_coef_pkg.sv
src/csd_input_stage.sv
src/csd_tap.sv
src/csd_output_stage.sv
src/csd_mult_bank.sv
test/tb_csd_mult_bank.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run the testbench, then check its log.

verilator --binary --timing --top-module tb_csd_mult_bank \
    -f csd_mult_bank.f --Mdir obj_dir -o tb_csd_mult_bank \
    || { echo "Verilator build failed."; exit 1; }

./obj_dir/tb_csd_mult_bank > sim.log 2>&1
cat sim.log

grep -q "SIMULATION FAILED" sim.log && { echo "Testbench reported a failure."; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "Run ended without a result."; exit 1; }
exit 0
